//--- verilog/rv_core_pkg.sv
package rv_core_pkg;

    //////////////////////////////
    // Widths and reset values
    //////////////////////////////

    localparam int XLEN    = 32;                    // Word width
    localparam int REG_SEL = 5;                     // Register index width

    localparam logic [XLEN-1:0] RESET_PC = '0;      // PC after reset

    //////////////////////////////
    // Major opcodes, instr[6:2]
    //////////////////////////////

    typedef enum logic [4:0] {
        OPC_R      = 5'b01100,                      // Register-register ALU
        OPC_I      = 5'b00100,                      // Register-immediate ALU
        OPC_LUI    = 5'b01101,
        OPC_AUIPC  = 5'b00101,
        OPC_JAL    = 5'b11011,
        OPC_JALR   = 5'b11001,
        OPC_BRANCH = 5'b11000                       // All six conditional branches
    } opcode_e;

    // ALU operations chosen by decode
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,                                    // Signed compare
        ALU_SLTU,                                   // Unsigned compare
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B                                  // LUI, operand_b straight through
    } alu_op_e;

    // Writeback source
    typedef enum logic {
        RES_ALU,                                    // ALU result
        RES_LINK                                    // PC+4 for JAL/JALR
    } res_sel_e;

    // Branch conditions by funct3
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

endpackage

//--- verilog/core_ifs.sv
// Decoded instruction, decode to execute
interface decode_bus_if;
    logic                                dec_valid;     // One-cycle pulse per instruction
    rv_core_pkg::alu_op_e                alu_op;
    rv_core_pkg::res_sel_e               res_sel;
    logic [2:0]                          funct3;        // Branch condition
    logic [rv_core_pkg::XLEN-1:0]        operand_a;
    logic [rv_core_pkg::XLEN-1:0]        operand_b;
    logic [rv_core_pkg::XLEN-1:0]        rs1_val;
    logic [rv_core_pkg::XLEN-1:0]        rs2_val;
    logic [rv_core_pkg::XLEN-1:0]        imm;
    logic [rv_core_pkg::XLEN-1:0]        pc_at_issue;
    logic [rv_core_pkg::REG_SEL-1:0]     rd;
    logic                                reg_write;
    logic                                branch;
    logic                                jump;          // JAL or JALR
    logic                                jalr;
    logic                                illegal;

    modport driver   (output dec_valid, alu_op, res_sel, funct3, operand_a, operand_b,
                      rs1_val, rs2_val, imm, pc_at_issue, rd, reg_write, branch, jump,
                      jalr, illegal);
    modport receiver (input  dec_valid, alu_op, res_sel, funct3, operand_a, operand_b,
                      rs1_val, rs2_val, imm, pc_at_issue, rd, reg_write, branch, jump,
                      jalr, illegal);
endinterface

// Execute result, execute to retire
interface exec_result_if;
    logic                                res_valid;     // One-cycle pulse
    logic [rv_core_pkg::REG_SEL-1:0]     rd;
    logic                                reg_write;
    logic [rv_core_pkg::XLEN-1:0]        value;         // Writeback data
    logic [rv_core_pkg::XLEN-1:0]        next_pc;
    logic                                illegal;

    modport driver   (output res_valid, rd, reg_write, value, next_pc, illegal);
    modport receiver (input  res_valid, rd, reg_write, value, next_pc, illegal);
endinterface

//--- verilog/reg_file.sv
module reg_file (
    input  logic                                clk,
    input  logic                                reset,
    input  logic [rv_core_pkg::REG_SEL-1:0]     rs1_addr,
    input  logic [rv_core_pkg::REG_SEL-1:0]     rs2_addr,
    output logic [rv_core_pkg::XLEN-1:0]        rs1_data,
    output logic [rv_core_pkg::XLEN-1:0]        rs2_data,
    input  logic                                wr_en,
    input  logic [rv_core_pkg::REG_SEL-1:0]     wr_addr,
    input  logic [rv_core_pkg::XLEN-1:0]        wr_data
);

    // x1..x31 only, x0 has no storage
    logic [rv_core_pkg::XLEN-1:0] regs [1:31];

    // Synchronous write port
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_addr != '0)) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Asynchronous reads, x0 reads as zero
    always_comb begin
        rs1_data = '0;
        rs2_data = '0;
        if (rs1_addr != '0) begin
            rs1_data = regs[rs1_addr];
        end
        if (rs2_addr != '0) begin
            rs2_data = regs[rs2_addr];
        end
    end

endmodule

//--- verilog/instr_decode.sv
module instr_decode (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                instr_req,
    input  logic [rv_core_pkg::XLEN-1:0]        instr,
    input  logic                                instr_ack,
    input  logic [rv_core_pkg::XLEN-1:0]        pc,
    output logic                                release_ack,    // Agent dropped instr_req
    output logic [rv_core_pkg::REG_SEL-1:0]     rs1_addr,
    output logic [rv_core_pkg::REG_SEL-1:0]     rs2_addr,
    input  logic [rv_core_pkg::XLEN-1:0]        rs1_data,
    input  logic [rv_core_pkg::XLEN-1:0]        rs2_data,
    decode_bus_if.driver                        dbus
);

    typedef enum logic [1:0] {ISSUE_IDLE, ISSUE_BUSY, ISSUE_RELEASE} issue_state_e;

    issue_state_e                       state;
    logic                               issue;
    rv_core_pkg::opcode_e               opcode;
    logic [2:0]                         funct3;
    logic [rv_core_pkg::REG_SEL-1:0]    rd;
    logic [rv_core_pkg::XLEN-1:0]       imm_i, imm_u, imm_j, imm_b;
    rv_core_pkg::alu_op_e               alu_op_c;
    rv_core_pkg::res_sel_e              res_sel_c;
    logic [rv_core_pkg::XLEN-1:0]       imm_c, op_a_c, op_b_c;
    logic                               has_rd, branch_c, jump_c, jalr_c, illegal_c;

    // funct3 plus the alternate bit gives the ALU op for R and I types
    function automatic rv_core_pkg::alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? rv_core_pkg::ALU_SUB : rv_core_pkg::ALU_ADD;
            3'b001:  return rv_core_pkg::ALU_SLL;
            3'b010:  return rv_core_pkg::ALU_SLT;
            3'b011:  return rv_core_pkg::ALU_SLTU;
            3'b100:  return rv_core_pkg::ALU_XOR;
            3'b101:  return alt ? rv_core_pkg::ALU_SRA : rv_core_pkg::ALU_SRL;
            3'b110:  return rv_core_pkg::ALU_OR;
            default: return rv_core_pkg::ALU_AND;
        endcase
    endfunction

    //////////////////////////////
    // Field extraction
    //////////////////////////////

    assign opcode   = rv_core_pkg::opcode_e'(instr[6:2]);
    assign funct3   = instr[14:12];
    assign rd       = instr[11:7];
    assign rs1_addr = instr[19:15];                 // Async read, instr held stable by agent
    assign rs2_addr = instr[24:20];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
    assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};

    // Opcode classification
    always_comb begin
        alu_op_c  = rv_core_pkg::ALU_ADD;
        res_sel_c = rv_core_pkg::RES_ALU;
        imm_c     = imm_i;
        op_a_c    = rs1_data;
        op_b_c    = rs2_data;
        has_rd    = 1'b1;
        branch_c  = 1'b0;
        jump_c    = 1'b0;
        jalr_c    = 1'b0;
        illegal_c = (instr[1:0] != 2'b11);          // Compressed encodings not supported
        case (opcode)
            rv_core_pkg::OPC_R: alu_op_c = alu_sel(funct3, instr[30]);
            rv_core_pkg::OPC_I: begin
                alu_op_c = alu_sel(funct3, instr[30] && (funct3 == 3'b101)); // No SUBI
                op_b_c   = imm_i;
            end
            rv_core_pkg::OPC_LUI: begin
                alu_op_c = rv_core_pkg::ALU_PASS_B;
                imm_c    = imm_u;
                op_b_c   = imm_u;
            end
            rv_core_pkg::OPC_AUIPC: begin
                imm_c  = imm_u;
                op_a_c = pc;
                op_b_c = imm_u;
            end
            rv_core_pkg::OPC_JAL: begin
                res_sel_c = rv_core_pkg::RES_LINK;
                jump_c    = 1'b1;
                imm_c     = imm_j;
            end
            rv_core_pkg::OPC_JALR: begin
                res_sel_c = rv_core_pkg::RES_LINK;
                jump_c    = 1'b1;
                jalr_c    = 1'b1;
                op_b_c    = imm_i;
                illegal_c = illegal_c || (funct3 != 3'b000);
            end
            rv_core_pkg::OPC_BRANCH: begin
                has_rd    = 1'b0;
                branch_c  = 1'b1;
                imm_c     = imm_b;
                illegal_c = illegal_c || (funct3[2:1] == 2'b01); // 010/011 undefined
            end
            default: begin                          // Loads, stores, fence, system
                has_rd    = 1'b0;
                illegal_c = 1'b1;
            end
        endcase
    end

    //////////////////////////////
    // Issue FSM
    //////////////////////////////

    assign issue = (state == ISSUE_IDLE) && instr_req && !instr_ack;

    always_ff @(posedge clk) begin
        if (reset) begin
            state          <= ISSUE_IDLE;
            dbus.dec_valid <= 1'b0;
            release_ack    <= 1'b0;
        end else begin
            dbus.dec_valid <= issue;                // Single pulse
            release_ack    <= 1'b0;
            case (state)
                ISSUE_IDLE:    if (issue) state <= ISSUE_BUSY;
                ISSUE_BUSY: begin
                    if (instr_ack && !instr_req) begin  // Phase 3 seen
                        release_ack <= 1'b1;
                        state       <= ISSUE_RELEASE;
                    end
                end
                ISSUE_RELEASE: if (!instr_ack) state <= ISSUE_IDLE;
                default:       state <= ISSUE_IDLE;
            endcase
        end
    end

    // Bundle register, loaded on issue
    always_ff @(posedge clk) begin
        if (issue) begin
            dbus.alu_op      <= alu_op_c;
            dbus.res_sel     <= res_sel_c;
            dbus.funct3      <= funct3;
            dbus.operand_a   <= op_a_c;
            dbus.operand_b   <= op_b_c;
            dbus.rs1_val     <= rs1_data;
            dbus.rs2_val     <= rs2_data;
            dbus.imm         <= imm_c;
            dbus.pc_at_issue <= pc;
            dbus.rd          <= rd;
            dbus.reg_write   <= has_rd && (rd != '0) && !illegal_c;
            dbus.branch      <= branch_c && !illegal_c;
            dbus.jump        <= jump_c && !illegal_c;
            dbus.jalr        <= jalr_c && !illegal_c;
            dbus.illegal     <= illegal_c;
        end
    end

endmodule

//--- verilog/alu_execute.sv
module alu_execute (
    input  logic                clk,
    input  logic                reset,
    decode_bus_if.receiver      dbus,
    exec_result_if.driver       rbus
);

    logic [rv_core_pkg::XLEN-1:0] a, b;
    logic [rv_core_pkg::XLEN-1:0] alu_res;
    logic [rv_core_pkg::XLEN-1:0] seq_pc, target_pc;
    logic [4:0]                   shamt;
    logic                         taken;

    assign a     = dbus.operand_a;
    assign b     = dbus.operand_b;
    assign shamt = b[4:0];                          // Low five bits only

    // ALU
    always_comb begin
        case (dbus.alu_op)
            rv_core_pkg::ALU_ADD:    alu_res = a + b;
            rv_core_pkg::ALU_SUB:    alu_res = a - b;
            rv_core_pkg::ALU_SLL:    alu_res = a << shamt;
            rv_core_pkg::ALU_SLT:    alu_res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            rv_core_pkg::ALU_SLTU:   alu_res = (a < b) ? 32'd1 : 32'd0;
            rv_core_pkg::ALU_XOR:    alu_res = a ^ b;
            rv_core_pkg::ALU_SRL:    alu_res = a >> shamt;
            rv_core_pkg::ALU_SRA:    alu_res = $signed(a) >>> shamt;
            rv_core_pkg::ALU_OR:     alu_res = a | b;
            rv_core_pkg::ALU_AND:    alu_res = a & b;
            rv_core_pkg::ALU_PASS_B: alu_res = b;
            default:                 alu_res = a + b;
        endcase
    end

    //////////////////////////////
    // Branch and next PC
    //////////////////////////////

    always_comb begin
        case (dbus.funct3)
            rv_core_pkg::F3_BEQ:  taken = (dbus.rs1_val == dbus.rs2_val);
            rv_core_pkg::F3_BNE:  taken = (dbus.rs1_val != dbus.rs2_val);
            rv_core_pkg::F3_BLT:  taken = ($signed(dbus.rs1_val) < $signed(dbus.rs2_val));
            rv_core_pkg::F3_BGE:  taken = ($signed(dbus.rs1_val) >= $signed(dbus.rs2_val));
            rv_core_pkg::F3_BLTU: taken = (dbus.rs1_val < dbus.rs2_val);
            rv_core_pkg::F3_BGEU: taken = (dbus.rs1_val >= dbus.rs2_val);
            default:              taken = 1'b0;
        endcase
        taken = taken && dbus.branch;               // Only meaningful for branches
    end

    assign seq_pc = dbus.pc_at_issue + 32'd4;       // Also the link value

    always_comb begin
        if (dbus.jalr) begin
            target_pc = (dbus.rs1_val + dbus.imm) & ~32'd1;  // Bit 0 cleared
        end else if (dbus.jump || taken) begin
            target_pc = dbus.pc_at_issue + dbus.imm;
        end else begin
            target_pc = seq_pc;
        end
    end

    // Result register
    always_ff @(posedge clk) begin
        if (reset) begin
            rbus.res_valid <= 1'b0;
        end else begin
            rbus.res_valid <= dbus.dec_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (dbus.dec_valid) begin
            rbus.rd        <= dbus.rd;
            rbus.reg_write <= dbus.reg_write;
            rbus.value     <= (dbus.res_sel == rv_core_pkg::RES_LINK) ? seq_pc : alu_res;
            rbus.next_pc   <= target_pc;
            rbus.illegal   <= dbus.illegal;
        end
    end

endmodule

//--- verilog/retire_unit.sv
module retire_unit (
    input  logic                                clk,
    input  logic                                reset,
    exec_result_if.receiver                     rbus,
    input  logic                                release_ack,
    output logic                                wr_en,
    output logic [rv_core_pkg::REG_SEL-1:0]     wr_addr,
    output logic [rv_core_pkg::XLEN-1:0]        wr_data,
    output logic [rv_core_pkg::XLEN-1:0]        pc,
    output logic                                instr_ack,
    output logic                                wb_valid,
    output logic [rv_core_pkg::REG_SEL-1:0]     wb_rd,
    output logic [rv_core_pkg::XLEN-1:0]        wb_data,
    output logic                                instr_illegal
);

    logic commit;

    // Register write happens on the same edge as the PC update
    assign commit  = rbus.res_valid && rbus.reg_write;
    assign wr_en   = commit;
    assign wr_addr = rbus.rd;
    assign wr_data = rbus.value;

    //////////////////////////////
    // PC and handshake flags
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            pc            <= rv_core_pkg::RESET_PC;
            instr_ack     <= 1'b0;
            wb_valid      <= 1'b0;
            instr_illegal <= 1'b0;
        end else begin
            wb_valid <= commit;                     // One cycle per writeback
            if (rbus.res_valid) begin
                pc            <= rbus.next_pc;
                instr_ack     <= 1'b1;              // Retired
                instr_illegal <= rbus.illegal;      // Held with the ack
            end else if (release_ack) begin
                instr_ack     <= 1'b0;              // Phase 4
                instr_illegal <= 1'b0;
            end
        end
    end

    // Writeback report
    always_ff @(posedge clk) begin
        if (commit) begin
            wb_rd   <= rbus.rd;
            wb_data <= rbus.value;
        end
    end

endmodule

//--- verilog/rv32_exec_core.sv
module rv32_exec_core (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                instr_req,
    input  logic [rv_core_pkg::XLEN-1:0]        instr,
    output logic                                instr_ack,
    output logic                                wb_valid,
    output logic [rv_core_pkg::REG_SEL-1:0]     wb_rd,
    output logic [rv_core_pkg::XLEN-1:0]        wb_data,
    output logic [rv_core_pkg::XLEN-1:0]        pc,
    output logic                                instr_illegal
);

    logic                               release_ack;    // Decode to retire
    logic [rv_core_pkg::REG_SEL-1:0]    rs1_addr, rs2_addr;
    logic [rv_core_pkg::XLEN-1:0]       rs1_data, rs2_data;
    logic                               wr_en;
    logic [rv_core_pkg::REG_SEL-1:0]    wr_addr;
    logic [rv_core_pkg::XLEN-1:0]       wr_data;

    decode_bus_if  u_dbus ();
    exec_result_if u_rbus ();

    reg_file u_reg_file (
        .clk      (clk),
        .reset    (reset),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data)
    );

    instr_decode u_decode (
        .clk         (clk),
        .reset       (reset),
        .instr_req   (instr_req),
        .instr       (instr),
        .instr_ack   (instr_ack),
        .pc          (pc),
        .release_ack (release_ack),
        .rs1_addr    (rs1_addr),
        .rs2_addr    (rs2_addr),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .dbus        (u_dbus.driver)
    );

    alu_execute u_execute (
        .clk   (clk),
        .reset (reset),
        .dbus  (u_dbus.receiver),
        .rbus  (u_rbus.driver)
    );

    retire_unit u_retire (
        .clk           (clk),
        .reset         (reset),
        .rbus          (u_rbus.receiver),
        .release_ack   (release_ack),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .pc            (pc),
        .instr_ack     (instr_ack),
        .wb_valid      (wb_valid),
        .wb_rd         (wb_rd),
        .wb_data       (wb_data),
        .instr_illegal (instr_illegal)
    );

endmodule

//--- verif/rv32_exec_core_asserts.sv
module rv32_exec_core_asserts (
    input logic                             clk,
    input logic                             reset,
    input logic                             instr_req,
    input logic                             instr_ack,
    input logic                             wb_valid,
    input logic [rv_core_pkg::REG_SEL-1:0]  wb_rd
);

    timeunit 1ns;
    timeprecision 100ps;

    //////////////////////////////
    // Handshake
    //////////////////////////////

    ack_after_req: assert property (@(posedge clk) disable iff (reset)
        $rose(instr_ack) |-> instr_req)
        else $error("instr_ack rose while instr_req was low");

    // Release then clear, two edges at most
    ack_drops: assert property (@(posedge clk) disable iff (reset)
        (!instr_req && instr_ack) |-> ##[1:2] !instr_ack)
        else $error("instr_ack stayed high after instr_req dropped");

    //////////////////////////////
    // Writeback
    //////////////////////////////

    wb_single_cycle: assert property (@(posedge clk) disable iff (reset)
        wb_valid |=> !wb_valid)
        else $error("wb_valid held longer than one cycle");

    wb_rd_nonzero: assert property (@(posedge clk) disable iff (reset)
        wb_valid |-> (wb_rd != '0))                 // x0 never reported
        else $error("wb_valid with wb_rd equal to x0");

endmodule

bind rv32_exec_core rv32_exec_core_asserts u_asserts (
    .clk       (clk),
    .reset     (reset),
    .instr_req (instr_req),
    .instr_ack (instr_ack),
    .wb_valid  (wb_valid),
    .wb_rd     (wb_rd)
);

//--- verif/tb_rv32_exec_core.sv
module tb_rv32_exec_core;

    timeunit 1ns;
    timeprecision 100ps;

    // One table row per instruction
    typedef struct {
        logic [31:0] instr;
        logic        expect_wb;
        logic [4:0]  rd;
        logic [31:0] data;
        logic [31:0] pc;                            // PC after retire
        logic        expect_illegal;
    } entry_t;

    logic        clk;
    logic        reset;
    logic        instr_req;
    logic [31:0] instr;
    logic        instr_ack;
    logic        wb_valid;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;
    logic [31:0] pc;
    logic        instr_illegal;

    entry_t      vectors[$];
    entry_t      cur;
    logic        table_ready = 1'b0;
    logic [15:0] lfsr;
    logic [1:0]  gap;

    rv32_exec_core u_dut (
        .clk           (clk),
        .reset         (reset),
        .instr_req     (instr_req),
        .instr         (instr),
        .instr_ack     (instr_ack),
        .wb_valid      (wb_valid),
        .wb_rd         (wb_rd),
        .wb_data       (wb_data),
        .pc            (pc),
        .instr_illegal (instr_illegal)
    );

    //////////////////////////////
    // Instruction encoders
    //////////////////////////////

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, rv_core_pkg::OPC_R, 2'b11};
    endfunction

    function automatic logic [31:0] alu_imm(input logic [11:0] imm, input logic [4:0] rs1,
                                            input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, rv_core_pkg::OPC_I, 2'b11};
    endfunction

    function automatic logic [31:0] jalr_instr(input logic [11:0] imm, input logic [4:0] rs1,
                                               input logic [4:0] rd);
        return {imm, rs1, 3'b000, rd, rv_core_pkg::OPC_JALR, 2'b11};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                           input rv_core_pkg::opcode_e opc);
        return {imm, rd, opc, 2'b11};
    endfunction

    // Offset bits scattered per the B format
    function automatic logic [31:0] b_type(input logic [12:0] off, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11],
                rv_core_pkg::OPC_BRANCH, 2'b11};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, rv_core_pkg::OPC_JAL, 2'b11};
    endfunction

    // Fibonacci LFSR, x^16+x^14+x^13+x^11+1, new bit enters at bit 0
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic add_entry(input logic [31:0] ins, input logic wb, input logic [4:0] rd,
                             input logic [31:0] data, input logic [31:0] pc_after,
                             input logic ill);
        entry_t e;
        e.instr          = ins;
        e.expect_wb      = wb;
        e.rd             = rd;
        e.data           = data;
        e.pc             = pc_after;
        e.expect_illegal = ill;
        vectors.push_back(e);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] t=%0t %s actual=0x%08h expected=0x%08h",
                     $time, name, actual, expected);
            $display("TEST RESULT: FAIL");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    // Expected values worked out by hand, x0..x31 zero and pc 0 at start
    task automatic build_table();
        add_entry(alu_imm(12'd5, 0, 3'b000, 1), 1, 1, 32'h5, 32'h4, 0);        // ADDI x1 = 5
        add_entry(alu_imm(12'hFFD, 0, 3'b000, 2), 1, 2, 32'hFFFFFFFD, 32'h8, 0); // x2 = -3
        add_entry(r_type(0, 2, 1, 3'b000, 3), 1, 3, 32'h2, 32'hC, 0);          // ADD
        add_entry(r_type(7'h20, 2, 1, 3'b000, 4), 1, 4, 32'h8, 32'h10, 0);     // SUB
        add_entry(r_type(0, 1, 1, 3'b001, 5), 1, 5, 32'hA0, 32'h14, 0);        // SLL by 5
        add_entry(r_type(0, 1, 2, 3'b101, 6), 1, 6, 32'h07FFFFFF, 32'h18, 0);  // SRL
        add_entry(r_type(7'h20, 1, 2, 3'b101, 7), 1, 7, 32'hFFFFFFFF, 32'h1C, 0); // SRA
        add_entry(r_type(0, 1, 2, 3'b010, 8), 1, 8, 32'h1, 32'h20, 0);         // SLT -3 < 5
        add_entry(r_type(0, 1, 2, 3'b011, 9), 1, 9, 32'h0, 32'h24, 0);         // SLTU, not less
        add_entry(r_type(0, 2, 1, 3'b100, 10), 1, 10, 32'hFFFFFFF8, 32'h28, 0); // XOR
        add_entry(r_type(0, 2, 1, 3'b110, 11), 1, 11, 32'hFFFFFFFD, 32'h2C, 0); // OR
        add_entry(r_type(0, 2, 1, 3'b111, 12), 1, 12, 32'h5, 32'h30, 0);       // AND
        add_entry(alu_imm(12'h401, 2, 3'b101, 13), 1, 13, 32'hFFFFFFFE, 32'h34, 0); // SRAI 1
        add_entry(alu_imm(12'd6, 1, 3'b010, 14), 1, 14, 32'h1, 32'h38, 0);     // SLTI
        add_entry(alu_imm(12'h0F0, 2, 3'b111, 15), 1, 15, 32'hF0, 32'h3C, 0);  // ANDI
        // LUI then AUIPC at pc 0x40
        add_entry(u_type(20'h12345, 16, rv_core_pkg::OPC_LUI), 1, 16, 32'h12345000, 32'h40, 0);
        add_entry(u_type(20'h00001, 17, rv_core_pkg::OPC_AUIPC), 1, 17, 32'h1040, 32'h44, 0);
        add_entry(alu_imm(12'd7, 1, 3'b000, 0), 0, 0, 32'h0, 32'h48, 0);       // Write to x0
        add_entry(r_type(0, 1, 0, 3'b000, 18), 1, 18, 32'h5, 32'h4C, 0);       // x0 + x1

        // Branches, taken then not taken per condition
        add_entry(b_type(13'd8, 18, 1, 3'b000), 0, 0, 32'h0, 32'h54, 0);       // BEQ
        add_entry(b_type(13'd8, 2, 1, 3'b000), 0, 0, 32'h0, 32'h58, 0);
        add_entry(b_type(13'd12, 2, 1, 3'b001), 0, 0, 32'h0, 32'h64, 0);       // BNE
        add_entry(b_type(13'd8, 18, 1, 3'b001), 0, 0, 32'h0, 32'h68, 0);
        add_entry(b_type(13'd16, 1, 2, 3'b100), 0, 0, 32'h0, 32'h78, 0);       // BLT
        add_entry(b_type(13'd8, 2, 1, 3'b100), 0, 0, 32'h0, 32'h7C, 0);
        add_entry(b_type(13'h1FF4, 2, 1, 3'b101), 0, 0, 32'h0, 32'h70, 0);     // BGE, back 12
        add_entry(b_type(13'd8, 1, 2, 3'b101), 0, 0, 32'h0, 32'h74, 0);
        add_entry(b_type(13'd8, 2, 1, 3'b110), 0, 0, 32'h0, 32'h7C, 0);        // BLTU
        add_entry(b_type(13'd8, 1, 2, 3'b110), 0, 0, 32'h0, 32'h80, 0);
        add_entry(b_type(13'd20, 1, 2, 3'b111), 0, 0, 32'h0, 32'h94, 0);       // BGEU
        add_entry(b_type(13'd8, 2, 1, 3'b111), 0, 0, 32'h0, 32'h98, 0);

        add_entry(j_type(21'h100, 19), 1, 19, 32'h9C, 32'h198, 0);             // JAL
        add_entry(jalr_instr(12'd7, 16, 20), 1, 20, 32'h19C, 32'h12345006, 0); // Odd target
        add_entry({12'd0, 5'd1, 3'b010, 5'd21, 7'b0000011}, 0, 0, 0, 32'h1234500A, 1); // LW
        add_entry({7'd0, 5'd1, 5'd2, 3'b010, 5'd0, 7'b0100011}, 0, 0, 0, 32'h1234500E, 1); // SW
        add_entry(alu_imm(12'd1, 20, 3'b000, 21), 1, 21, 32'h19D, 32'h12345012, 0);
    endtask

    // 20 ns clock
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Watchdog, 16 cycles per entry plus reset
    initial begin
        wait (table_ready);
        #(vectors.size() * 16 * 20 + 4 * 20);
        $display("Timeout: the instr_req/instr_ack handshake hung and never completed");
        $display("TEST RESULT: FAIL");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        reset     = 1'b1;
        instr_req = 1'b0;
        instr     = '0;
        lfsr      = 16'd10;                         // Seed
        build_table();
        table_ready = 1'b1;
        repeat (4) @(posedge clk);
        reset <= 1'b0;

        foreach (vectors[i]) begin
            cur = vectors[i];
            @(posedge clk);
            instr     <= cur.instr;
            instr_req <= 1'b1;
            @(negedge clk);
            while (!instr_ack) @(negedge clk);      // Retire seen
            check_value("wb_valid", wb_valid, cur.expect_wb);
            if (cur.expect_wb) begin
                check_value("wb_rd", wb_rd, cur.rd);
                check_value("wb_data", wb_data, cur.data);
            end
            check_value("pc", pc, cur.pc);
            check_value("instr_illegal", instr_illegal, cur.expect_illegal);
            @(posedge clk);
            instr_req <= 1'b0;                      // Phase 3
            @(negedge clk);
            while (instr_ack) @(negedge clk);
            // Two LFSR bits give 0..3 idle cycles
            lfsr   = lfsr_next(lfsr);
            gap[0] = lfsr[0];
            lfsr   = lfsr_next(lfsr);
            gap[1] = lfsr[0];
            repeat (gap) @(posedge clk);
        end

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

//--- filelist.f
verilog/rv_core_pkg.sv
verilog/core_ifs.sv
verilog/reg_file.sv
verilog/instr_decode.sv
verilog/alu_execute.sv
verilog/retire_unit.sv
verilog/rv32_exec_core.sv
verif/rv32_exec_core_asserts.sv
verif/tb_rv32_exec_core.sv
